/* common/video_regs_pkg.sv */
/*
 * CPU side register definitions
 * I/O bus word, port numbers and the write requests sent from the
 * CPU port to the pixel pipeline
 */

package video_regs_pkg;

	// -------------------------------------------------------------------------
	// CPU I/O bus
	// -------------------------------------------------------------------------

	// strobes are active low, write taken on the rising wr_n
	typedef struct packed {
		logic       iorq_n;
		logic       wr_n;
		logic [7:0] address;
		logic [7:0] wdata;
	} cpu_bus_t;

	// port map
	localparam logic [7:0] port_pal_index = 8'h20;
	localparam logic [7:0] port_pal_data  = 8'h21;
	localparam logic [7:0] port_line_addr = 8'h22;
	localparam logic [7:0] port_line_data = 8'h23;

	// -------------------------------------------------------------------------
	// colour and write requests
	// -------------------------------------------------------------------------

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// held until the pixel pipeline accepts it
	typedef struct packed {
		logic       req;
		logic [7:0] index;
		rgb_t       rgb;
	} pal_wr_t;

	// one line of up to 1024 pixel indices
	typedef logic [9:0] line_addr_t;

	// single clock strobe, no back-pressure
	typedef struct packed {
		logic       en;
		line_addr_t addr;
		logic [7:0] data;
	} line_wr_t;

endpackage

/* common/video_timing_pkg.sv */
/*
 * raster timing types
 * counter word and the raster status word shared by the timer
 * and the pixel pipeline
 */

package video_timing_pkg;

	// -------------------------------------------------------------------------
	// counters
	// -------------------------------------------------------------------------

	// wide enough for 720p totals and smaller modes
	typedef logic [11:0] count_t;

	// -------------------------------------------------------------------------
	// raster status
	// -------------------------------------------------------------------------

	// all fields registered in the timer and aligned to the counter values
	typedef struct packed {
		// position inside the frame
		count_t h_count;
		count_t v_count;
		// active area flags, de is h_window and v_window
		logic   h_window;
		logic   v_window;
		// positive sync pulses
		logic   hs;
		logic   vs;
	} raster_t;

endpackage

/* hw/cpu_port/cpu_reg_fsm.sv */
/*
 * CPU register port
 * detects I/O write edges, sequences the palette index and colour
 * elements, and the line address with auto-incrementing pixel writes
 */
`timescale 1ns/100ps

module cpu_reg_fsm import video_regs_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  cpu_bus_t cpu,
	input  logic     pal_accept,
	output pal_wr_t  pal_wr,
	output line_wr_t line_wr
);

	typedef enum logic [1:0] {
		elem_r,
		elem_g,
		elem_b
	} elem_t;

	logic       iorq_n_q;
	logic       wr_n_q;
	logic       wr_stb;
	logic       wr_pal_index;
	logic       wr_pal_data;
	logic       wr_line_addr;
	logic       wr_line_data;
	logic [7:0] pal_index;
	elem_t      elem;
	logic [7:0] r_hold;
	logic [7:0] g_hold;
	logic       pal_req;
	logic [7:0] pal_req_index;
	rgb_t       pal_req_rgb;
	line_addr_t line_addr;
	logic       addr_high;
	logic       line_en;
	line_addr_t line_wr_addr;
	logic [7:0] line_wr_data;

	// -------------------------------------------------------------------------
	// write edge
	// -------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			iorq_n_q <= 1'b1;
			wr_n_q   <= 1'b1;
		end else begin
			iorq_n_q <= cpu.iorq_n;
			wr_n_q   <= cpu.wr_n;
		end
	end

	// cycle was active last clock, wr_n released now
	assign wr_stb       = !iorq_n_q && !wr_n_q && cpu.wr_n;
	assign wr_pal_index = wr_stb && (cpu.address == port_pal_index);
	assign wr_pal_data  = wr_stb && (cpu.address == port_pal_data);
	assign wr_line_addr = wr_stb && (cpu.address == port_line_addr);
	assign wr_line_data = wr_stb && (cpu.address == port_line_data);

	// -------------------------------------------------------------------------
	// palette sequencing
	// -------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pal_index <= '0;
			elem      <= elem_r;
		end else if (wr_pal_index) begin
			pal_index <= cpu.wdata;
			elem      <= elem_r;
		end else if (wr_pal_data) begin
			case (elem)
				elem_r:  elem <= elem_g;
				elem_g:  elem <= elem_b;
				default: begin
					// triplet done, wraps at 255
					elem      <= elem_r;
					pal_index <= pal_index + 8'd1;
				end
			endcase
		end
	end

	// r and g wait here for the blue byte
	always_ff @(posedge clk) begin
		if (wr_pal_data && elem == elem_r) begin
			r_hold <= cpu.wdata;
		end
		if (wr_pal_data && elem == elem_g) begin
			g_hold <= cpu.wdata;
		end
	end

	// a new triplet wins over the accept of the old one
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pal_req <= 1'b0;
		end else if (wr_pal_data && elem == elem_b) begin
			pal_req <= 1'b1;
		end else if (pal_accept) begin
			pal_req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_pal_data && elem == elem_b) begin
			pal_req_index <= pal_index;
			pal_req_rgb   <= '{r: r_hold, g: g_hold, b: cpu.wdata};
		end
	end

	assign pal_wr = '{req: pal_req, index: pal_req_index, rgb: pal_req_rgb};

	// -------------------------------------------------------------------------
	// line address and pixel data
	// -------------------------------------------------------------------------

	// low byte then high byte, then auto-increment per data write
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			line_addr <= '0;
			addr_high <= 1'b0;
		end else if (wr_line_addr) begin
			if (!addr_high) begin
				line_addr[7:0] <= cpu.wdata;
			end else begin
				line_addr[9:8] <= cpu.wdata[1:0];
			end
			addr_high <= !addr_high;
		end else if (wr_line_data) begin
			line_addr <= line_addr + 10'd1;
		end
	end

	// one clock strobe
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			line_en <= 1'b0;
		end else begin
			line_en <= wr_line_data;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_line_data) begin
			line_wr_addr <= line_addr;
			line_wr_data <= cpu.wdata;
		end
	end

	assign line_wr = '{en: line_en, addr: line_wr_addr, data: line_wr_data};

endmodule

/* hw/pixel/line_memory.sv */
/*
 * line memory
 * 1024 pixel indices, one write port for the CPU side and one
 * registered read port for display
 */
`timescale 1ns/100ps

module line_memory (
	input  logic                      clk,
	// CPU side
	input  logic                      we,
	input  video_regs_pkg::line_addr_t waddr,
	input  logic [7:0]                wdata,
	// display side
	input  video_regs_pkg::line_addr_t raddr,
	output logic [7:0]                rdata
);

	logic [7:0] mem [0:1023];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// one clock read latency
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

/* hw/pixel/palette_ram.sv */
/*
 * palette memory
 * 256 entries of 24-bit colour, single port with registered read,
 * shared between display reads and CPU writes
 */
`timescale 1ns/100ps

module palette_ram (
	input  logic                 clk,
	input  logic [7:0]           address,
	input  logic                 we,
	input  video_regs_pkg::rgb_t wdata,
	output video_regs_pkg::rgb_t rdata
);

	video_regs_pkg::rgb_t mem [0:255];

	// write slot
	always_ff @(posedge clk) begin
		if (we) begin
			mem[address] <= wdata;
		end
	end

	// read-first
	// on a write clock rdata carries the old entry and is not used
	always_ff @(posedge clk) begin
		rdata <= mem[address];
	end

endmodule

/* hw/pixel/pixel_pipe.sv */
/*
 * pixel pipeline
 * line memory read, palette lookup shared with CPU writes, colour
 * register and matching delay of de, hs and vs, three clocks in all
 */
`timescale 1ns/100ps

module pixel_pipe import video_timing_pkg::*, video_regs_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  raster_t  raster,
	input  pal_wr_t  pal_wr,
	input  line_wr_t line_wr,
	output logic     pal_accept,
	output logic     video_de,
	output logic     video_hs,
	output logic     video_vs,
	output rgb_t     video_rgb
);

	count_t     x_pos;
	line_addr_t line_raddr;
	logic [7:0] pixel_index;
	logic [7:0] pal_addr;
	rgb_t       pal_rdata;
	logic       odd_1;
	logic       odd_2;
	logic [2:0] ctrl_0;
	logic [2:0] ctrl_1;
	logic [2:0] ctrl_2;
	logic [2:0] ctrl_3;
	rgb_t       rgb_q;

	// -------------------------------------------------------------------------
	// stage 0, line read
	// -------------------------------------------------------------------------

	// clocks since window start, zero on the first window clock
	always_ff @(posedge clk) begin
		if (!reset_n || !raster.h_window) begin
			x_pos <= '0;
		end else begin
			x_pos <= x_pos + 12'd1;
		end
	end

	// each index covers two clocks
	assign line_raddr = x_pos[10:1];

	line_memory u_line (
		.clk   (clk),
		.we    (line_wr.en),
		.waddr (line_wr.addr),
		.wdata (line_wr.data),
		.raddr (line_raddr),
		.rdata (pixel_index)
	);

	// -------------------------------------------------------------------------
	// stage 1, palette port
	// -------------------------------------------------------------------------

	// parity of the count whose index is now on the palette address
	// sync plus back porch is even, so a pixel starts on an even count
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			odd_1 <= 1'b0;
			odd_2 <= 1'b0;
		end else begin
			odd_1 <= raster.h_count[0];
			odd_2 <= odd_1;
		end
	end

	// even slot reads for display, odd slot belongs to the CPU
	assign pal_accept = pal_wr.req && odd_1;
	assign pal_addr   = odd_1 ? pal_wr.index : pixel_index;

	palette_ram u_palette (
		.clk     (clk),
		.address (pal_addr),
		.we      (pal_accept),
		.wdata   (pal_wr.rgb),
		.rdata   (pal_rdata)
	);

	// -------------------------------------------------------------------------
	// stage 2, colour register and control delay
	// -------------------------------------------------------------------------

	// de, hs, vs
	assign ctrl_0 = {raster.h_window && raster.v_window, raster.hs, raster.vs};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ctrl_1 <= '0;
			ctrl_2 <= '0;
			ctrl_3 <= '0;
		end else begin
			ctrl_1 <= ctrl_0;
			ctrl_2 <= ctrl_1;
			ctrl_3 <= ctrl_2;
		end
	end

	// loads after an even read and holds across the CPU slot
	// black outside the active area
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rgb_q <= '0;
		end else if (!odd_2) begin
			rgb_q <= ctrl_2[2] ? pal_rdata : '0;
		end
	end

	assign video_de  = ctrl_3[2];
	assign video_hs  = ctrl_3[1];
	assign video_vs  = ctrl_3[0];
	assign video_rgb = rgb_q;

endmodule

/* hw/raster/raster_timer.sv */
/*
 * raster timer
 * free-running horizontal and vertical counters with registered sync
 * and window flags, every flag aligned to the counter value it belongs to
 */
`timescale 1ns/100ps

module raster_timer import video_timing_pkg::*; #(
	parameter count_t h_total  = 12'd1650,
	parameter count_t h_sync   = 12'd40,
	parameter count_t h_bporch = 12'd220,
	parameter count_t h_res    = 12'd1280,
	parameter count_t v_total  = 12'd750,
	parameter count_t v_sync   = 12'd5,
	parameter count_t v_bporch = 12'd20,
	parameter count_t v_res    = 12'd720
) (
	input  logic    clk,
	input  logic    reset_n,
	output raster_t raster
);

	count_t h_count;
	count_t v_count;
	logic   h_window;
	logic   v_window;
	logic   hs;
	logic   vs;
	logic   h_end;
	logic   v_end;

	// last count of a line and of a frame
	assign h_end = (h_count == h_total - 12'd1);
	assign v_end = (v_count == v_total - 12'd1);

	// -------------------------------------------------------------------------
	// counters
	// -------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			h_count <= '0;
		end else if (h_end) begin
			h_count <= '0;
		end else begin
			h_count <= h_count + 12'd1;
		end
	end

	// steps once per line
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			v_count <= '0;
		end else if (h_end) begin
			v_count <= v_end ? '0 : v_count + 12'd1;
		end
	end

	// -------------------------------------------------------------------------
	// horizontal flags
	// -------------------------------------------------------------------------

	// decided one count early so the flag lines up with the counter
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			hs       <= 1'b0;
			h_window <= 1'b0;
		end else begin
			// sync from count 0 for h_sync clocks
			if (h_end) begin
				hs <= 1'b1;
			end else if (h_count == h_sync - 12'd1) begin
				hs <= 1'b0;
			end
			// window after sync and back porch
			if (h_count == h_sync + h_bporch - 12'd1) begin
				h_window <= 1'b1;
			end else if (h_count == h_sync + h_bporch + h_res - 12'd1) begin
				h_window <= 1'b0;
			end
		end
	end

	// -------------------------------------------------------------------------
	// vertical flags
	// -------------------------------------------------------------------------

	// only at line end
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			vs       <= 1'b0;
			v_window <= 1'b0;
		end else if (h_end) begin
			if (v_end) begin
				vs <= 1'b1;
			end else if (v_count == v_sync - 12'd1) begin
				vs <= 1'b0;
			end
			if (v_count == v_sync + v_bporch - 12'd1) begin
				v_window <= 1'b1;
			end else if (v_count == v_sync + v_bporch + v_res - 12'd1) begin
				v_window <= 1'b0;
			end
		end
	end

	assign raster = '{h_count: h_count, v_count: v_count, h_window: h_window,
		v_window: v_window, hs: hs, vs: vs};

endmodule

/* hw/video_top.sv */
/*
 * display controller top level
 * raster timer, CPU register port and pixel pipeline
 */
`timescale 1ns/100ps

module video_top import video_timing_pkg::*, video_regs_pkg::*; #(
	// 1280x720 defaults
	parameter count_t h_total  = 12'd1650,
	parameter count_t h_sync   = 12'd40,
	parameter count_t h_bporch = 12'd220,
	parameter count_t h_res    = 12'd1280,
	parameter count_t v_total  = 12'd750,
	parameter count_t v_sync   = 12'd5,
	parameter count_t v_bporch = 12'd20,
	parameter count_t v_res    = 12'd720
) (
	input  logic     clk,
	input  logic     reset_n,
	// CPU I/O bus
	input  cpu_bus_t cpu,
	// monitor side
	output logic     video_de,
	output logic     video_hs,
	output logic     video_vs,
	output rgb_t     video_rgb
);

	raster_t  raster;
	pal_wr_t  pal_wr;
	line_wr_t line_wr;
	logic     pal_accept;

	// frame timing
	raster_timer #(
		.h_total  (h_total),
		.h_sync   (h_sync),
		.h_bporch (h_bporch),
		.h_res    (h_res),
		.v_total  (v_total),
		.v_sync   (v_sync),
		.v_bporch (v_bporch),
		.v_res    (v_res)
	) u_raster (
		.clk     (clk),
		.reset_n (reset_n),
		.raster  (raster)
	);

	// ports 0x20 to 0x23
	cpu_reg_fsm u_cpu_port (
		.clk        (clk),
		.reset_n    (reset_n),
		.cpu        (cpu),
		.pal_accept (pal_accept),
		.pal_wr     (pal_wr),
		.line_wr    (line_wr)
	);

	// line memory, palette and output registers
	pixel_pipe u_pixel (
		.clk        (clk),
		.reset_n    (reset_n),
		.raster     (raster),
		.pal_wr     (pal_wr),
		.line_wr    (line_wr),
		.pal_accept (pal_accept),
		.video_de   (video_de),
		.video_hs   (video_hs),
		.video_vs   (video_vs),
		.video_rgb  (video_rgb)
	);

endmodule

/* list.f */
common/video_timing_pkg.sv
common/video_regs_pkg.sv
hw/raster/raster_timer.sv
hw/cpu_port/cpu_reg_fsm.sv
hw/pixel/line_memory.sv
hw/pixel/palette_ram.sv
hw/pixel/pixel_pipe.sv
hw/video_top.sv
tests/video_props.sv
tests/tb_video.sv

/* run.sh */
#!/bin/sh
# build the display controller testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -f list.f --top-module tb_video \
	--Mdir obj_dir -o tb_video; then
	echo "verilator build failed"
	exit 1
fi

# high error limit so a failing assertion does not stop the run early
if ! ./obj_dir/tb_video +verilator+error+limit+1000 > "$log" 2>&1; then
	cat "$log"
	echo "simulation exited with an error status"
	exit 1
fi

cat "$log"

if grep -q "All tests passed!" "$log"; then
	exit 0
fi

echo "pass message not found in $log"
exit 1

/* tests/tb_video.sv */
/*
 * display controller testbench
 * loads line and palette through the CPU port, then compares every
 * active pixel and the sync widths against a reference model
 */
`timescale 1ns/100ps

module tb_video import video_timing_pkg::*, video_regs_pkg::*; ();

	// small raster, 40 x 12 clocks
	localparam count_t h_total  = 12'd40;
	localparam count_t h_sync   = 12'd4;
	localparam count_t h_bporch = 12'd6;
	localparam count_t h_res    = 12'd24;
	localparam count_t v_total  = 12'd12;
	localparam count_t v_sync   = 12'd2;
	localparam count_t v_bporch = 12'd2;
	localparam count_t v_res    = 12'd6;

	logic       clk;
	logic       reset_n;
	cpu_bus_t   cpu;
	logic       video_de;
	logic       video_hs;
	logic       video_vs;
	rgb_t       video_rgb;
	// reference model of the port state and both memories
	rgb_t       model_pal [0:255];
	logic [7:0] model_line [0:1023];
	logic [7:0] m_index;
	int         m_elem;
	logic [7:0] m_r;
	logic [7:0] m_g;
	line_addr_t m_line_addr;
	logic       m_addr_high;
	logic       model_ready;
	logic       cpu_busy;
	// compare state
	int         mismatch_count;
	int         other_errors;
	int         rows_seen;
	int         rows_checked;
	int         rows_in_frame;
	int         pixel_x;
	int         hs_len;
	int         vs_len;
	logic       row_ok;
	logic       sync_seen;
	logic       frame_seen;
	logic       de_q;
	logic       hs_q;
	logic       vs_q;

	video_top #(
		.h_total  (h_total),
		.h_sync   (h_sync),
		.h_bporch (h_bporch),
		.h_res    (h_res),
		.v_total  (v_total),
		.v_sync   (v_sync),
		.v_bporch (v_bporch),
		.v_res    (v_res)
	) u_dut (
		.clk       (clk),
		.reset_n   (reset_n),
		.cpu       (cpu),
		.video_de  (video_de),
		.video_hs  (video_hs),
		.video_vs  (video_vs),
		.video_rgb (video_rgb)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// -------------------------------------------------------------------------
	// reference model and checks
	// -------------------------------------------------------------------------

	// pixel x of a row shows palette entry of line entry x/2
	function automatic rgb_t expected_rgb(input int x);
		return model_pal[model_line[10'(x / 2)]];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	// port rules for one accepted write
	task automatic apply_model(input logic [7:0] addr, input logic [7:0] data);
		case (addr)
			port_pal_index: begin
				m_index = data;
				m_elem  = 0;
			end
			port_pal_data: begin
				if (m_elem == 0) begin
					m_r = data;
				end else if (m_elem == 1) begin
					m_g = data;
				end else begin
					model_pal[m_index] = '{r: m_r, g: m_g, b: data};
					m_index++;
				end
				m_elem = (m_elem + 1) % 3;
			end
			port_line_addr: begin
				if (!m_addr_high) begin
					m_line_addr[7:0] = data;
				end else begin
					m_line_addr[9:8] = data[1:0];
				end
				m_addr_high = !m_addr_high;
			end
			port_line_data: begin
				model_line[m_line_addr] = data;
				m_line_addr = m_line_addr + 10'd1;
			end
			default: ;
		endcase
	endtask

	// -------------------------------------------------------------------------
	// CPU bus
	// -------------------------------------------------------------------------

	// strobes low for 2 clocks, then settle time for palette and line writes
	task automatic bus_cycle(input logic [7:0] addr, input logic [7:0] data,
		input logic iorq_n_level);
		cpu_busy = 1'b1;
		@(negedge clk);
		cpu.address = addr;
		cpu.wdata   = data;
		cpu.iorq_n  = iorq_n_level;
		cpu.wr_n    = 1'b0;
		repeat (2) @(negedge clk);
		cpu.wr_n   = 1'b1;
		cpu.iorq_n = 1'b1;
		repeat (8) @(negedge clk);
		if (!iorq_n_level) begin
			apply_model(addr, data);
		end
		cpu_busy = 1'b0;
	endtask

	task automatic io_write(input logic [7:0] addr, input logic [7:0] data);
		bus_cycle(addr, data, 1'b0);
	endtask

	// low byte then high byte
	task automatic set_line_addr(input line_addr_t addr);
		io_write(port_line_addr, addr[7:0]);
		io_write(port_line_addr, {6'd0, addr[9:8]});
	endtask

	// -------------------------------------------------------------------------
	// bounded waits
	// -------------------------------------------------------------------------

	task automatic wait_rows(input int n);
		int target;
		int clocks;
		target = rows_seen + n;
		clocks = 0;
		while (rows_seen < target && clocks < (n + int'(v_total)) * 2 * int'(h_total)) begin
			@(negedge clk);
			clocks++;
		end
		if (rows_seen < target) begin
			other_errors++;
			$display("ERROR: timed out at %0t waiting for %0d display rows", $time, n);
		end
	endtask

	task automatic wait_first_sync();
		int clocks;
		clocks = 0;
		while (!sync_seen && clocks < 4 * int'(h_total)) begin
			@(negedge clk);
			clocks++;
		end
		if (!sync_seen) begin
			other_errors++;
			$display("ERROR: no horizontal sync within %0d clocks of reset", clocks);
		end
	endtask

	task automatic wait_active();
		int clocks;
		clocks = 0;
		while (!video_de && clocks < 2 * int'(v_total) * int'(h_total)) begin
			@(negedge clk);
			clocks++;
		end
		if (!video_de) begin
			other_errors++;
			$display("ERROR: timed out at %0t waiting for active video", $time);
		end
	endtask

	// -------------------------------------------------------------------------
	// compare process, sampled mid high phase
	// -------------------------------------------------------------------------

	initial begin : compare_outputs
		forever begin
			@(posedge clk);
			#2;
			if (!reset_n) begin
				{sync_seen, frame_seen, row_ok, de_q, hs_q, vs_q} = '0;
				hs_len        = 0;
				vs_len        = 0;
				pixel_x       = 0;
				rows_in_frame = 0;
			end else begin
				// quiet until the first sync
				if (!sync_seen && !video_hs) begin
					check_value("video_de", 32'(video_de), 32'd0);
					check_value("video_vs", 32'(video_vs), 32'd0);
					check_value("video_rgb", 32'(video_rgb), 32'd0);
				end
				sync_seen = sync_seen || video_hs;
				if (video_hs) begin
					hs_len++;
				end else if (hs_q) begin
					check_value("video_hs width", 32'(hs_len), 32'(h_sync));
					hs_len = 0;
				end
				// frame start, active rows of the last frame
				if (video_vs && !vs_q) begin
					if (frame_seen) begin
						check_value("rows per frame", 32'(rows_in_frame), 32'(v_res));
					end
					frame_seen    = 1'b1;
					rows_in_frame = 0;
				end
				if (video_vs) begin
					vs_len++;
				end else if (vs_q) begin
					check_value("video_vs width", 32'(vs_len), 32'(v_sync) * 32'(h_total));
					vs_len = 0;
				end
				// pixels, row skipped if the CPU was busy during it
				if (video_de) begin
					if (!de_q) begin
						pixel_x = 0;
						row_ok  = model_ready && !cpu_busy;
						rows_in_frame++;
					end
					if (cpu_busy) begin
						row_ok = 1'b0;
					end
					if (row_ok) begin
						check_value("video_rgb", 32'(video_rgb), 32'(expected_rgb(pixel_x)));
					end
					pixel_x++;
				end else if (de_q) begin
					check_value("video_de width", 32'(pixel_x), 32'(h_res));
					if (row_ok) begin
						rows_checked++;
					end
					rows_seen++;
				end
				de_q = video_de;
				hs_q = video_hs;
				vs_q = video_vs;
			end
		end
	end

	// -------------------------------------------------------------------------
	// stimulus
	// -------------------------------------------------------------------------

	initial begin : stimulus
		int i;
		void'($urandom(83726));
		reset_n        = 1'b0;
		cpu            = '{iorq_n: 1'b1, wr_n: 1'b1, address: 8'h00, wdata: 8'h00};
		cpu_busy       = 1'b0;
		model_ready    = 1'b0;
		mismatch_count = 0;
		other_errors   = 0;
		rows_seen      = 0;
		rows_checked   = 0;
		m_index        = 8'h00;
		m_elem         = 0;
		m_line_addr    = '0;
		m_addr_high    = 1'b0;
		repeat (5) @(negedge clk);
		reset_n = 1'b1;
		wait_first_sync();

		// displayed line from address 0
		set_line_addr(10'd0);
		for (i = 0; i < 12; i++) begin
			io_write(port_line_data, 8'($urandom));
		end
		// whole palette from 0xf0, wraps past 0xff
		io_write(port_pal_index, 8'hf0);
		for (i = 0; i < 768; i++) begin
			io_write(port_pal_data, 8'($urandom));
		end
		model_ready = 1'b1;
		wait_rows(12);

		// high address byte, entries beyond the shown line
		bus_cycle(port_line_addr, 8'h33, 1'b1);
		set_line_addr(10'h105);
		for (i = 0; i < 4; i++) begin
			io_write(port_line_data, 8'($urandom));
		end
		// partial rewrite with an ignored cycle in between
		set_line_addr(10'd6);
		io_write(port_line_data, 8'($urandom));
		bus_cycle(port_line_data, 8'ha5, 1'b1);
		io_write(8'h1f, 8'h22);
		io_write(port_line_data, 8'($urandom));
		io_write(port_line_data, 8'($urandom));
		wait_rows(6);

		// triplet interrupted by ignored cycles, then an index restart
		io_write(port_pal_index, model_line[2]);
		io_write(port_pal_data, 8'h12);
		bus_cycle(port_pal_data, 8'h5a, 1'b1);
		io_write(8'h24, 8'h11);
		io_write(port_pal_data, 8'h34);
		io_write(port_pal_data, 8'h56);
		io_write(port_pal_index, model_line[4]);
		io_write(port_pal_data, 8'h9a);
		io_write(port_pal_index, model_line[4]);
		repeat (3) io_write(port_pal_data, 8'($urandom));
		wait_rows(6);

		// palette updates issued during active pixels
		for (i = 0; i < 4; i++) begin
			wait_active();
			io_write(port_pal_index, model_line[i * 3]);
			repeat (3) io_write(port_pal_data, 8'($urandom));
			wait_rows(6);
		end

		if (rows_checked == 0) begin
			other_errors++;
			$display("ERROR: no active row was compared");
		end
		$display("summary: %0d mismatches, %0d other errors, %0d assertion failures, %0d rows",
			mismatch_count, other_errors, u_dut.u_props.fail_count, rows_checked);
		if (mismatch_count == 0 && other_errors == 0 && u_dut.u_props.fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* tests/video_props.sv */
/*
 * display controller assertions
 * sync and active video exclusion, palette request lifetime and quiet
 * outputs between reset and the first active pixel
 */
`timescale 1ns/100ps

module video_props import video_regs_pkg::*; (
	input logic    clk,
	input logic    reset_n,
	input logic    video_de,
	input logic    video_hs,
	input logic    video_vs,
	input rgb_t    video_rgb,
	input pal_wr_t pal_wr
);

	// assertion failures so far
	int unsigned fail_count = 0;
	logic        de_seen;

	// first active pixel since reset
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			de_seen <= 1'b0;
		end else if (video_de) begin
			de_seen <= 1'b1;
		end
	end

	// active video never overlaps the sync pulse
	de_outside_hs: assert property (@(posedge clk) disable iff (!reset_n)
		!(video_de && video_hs))
	else begin
		$error("video_de high while video_hs is high");
		fail_count++;
	end

	// accepted in the next odd slot, so never pending for 4 samples
	pal_req_clears: assert property (@(posedge clk) disable iff (!reset_n)
		!(pal_wr.req && $past(pal_wr.req) && $past(pal_wr.req, 2) && $past(pal_wr.req, 3)))
	else begin
		$error("palette request still pending after 3 clocks");
		fail_count++;
	end

	// black and no vertical sync before the first window
	quiet_after_reset: assert property (@(posedge clk) disable iff (!reset_n)
		(!de_seen && !video_de) |-> (video_rgb == '0 && !video_vs))
	else begin
		$error("outputs active before the first display window");
		fail_count++;
	end

endmodule

bind video_top video_props u_props (
	.clk       (clk),
	.reset_n   (reset_n),
	.video_de  (video_de),
	.video_hs  (video_hs),
	.video_vs  (video_vs),
	.video_rgb (video_rgb),
	.pal_wr    (pal_wr)
);
